// ==== collectorArbiter.sv ====
module collectorArbiter (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                done0,
    input  logic                                done1,
    input  logic [streamPkg::countWidth-1:0]    count0,
    input  logic [streamPkg::countWidth-1:0]    count1,
    input  logic [streamPkg::slotWidth-1:0]     slot0,
    input  logic [streamPkg::slotWidth-1:0]     slot1,
    output logic                                grant0,
    output logic                                grant1,
    output logic                                writeEnable,
    output logic [streamPkg::countWidth-1:0]    writeCount,
    output logic [streamPkg::slotWidth-1:0]     writeSlot
);

    // Low favors unit 0 on a tie
    logic favorOne;

    assign grant0 = done0 && (!done1 || !favorOne);
    assign grant1 = done1 && (!done0 || favorOne);
    assign writeEnable = grant0 || grant1;

    // Winner's result onto the single memory port
    assign writeCount = grant1 ? count1 : count0;
    assign writeSlot = grant1 ? slot1 : slot0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            favorOne <= 1'b0;
        end else if (done0 && done1) begin
            favorOne <= !favorOne;
        end
    end

endmodule

// ==== computePkg.sv ====
package computePkg;

    // How bot is combined with the shared top pattern
    typedef enum logic [1:0] {
        opAnd  = 2'd0,
        opOr   = 2'd1,
        opXor  = 2'd2,
        opNone = 2'd3
    } opcodeT;

    // Counting unit FSM
    typedef enum logic [1:0] {
        idle,
        load,
        count,
        hold
    } unitStateT;

endpackage

// ==== connectCounter.sv ====
module connectCounter (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                start,
    input  logic [streamPkg::dataWidth-1:0]     top,
    input  logic [streamPkg::dataWidth-1:0]     bot,
    input  computePkg::opcodeT                  op,
    input  logic [streamPkg::slotWidth-1:0]     slotIn,
    output logic                                idle,
    output logic                                done,
    output logic [streamPkg::countWidth-1:0]    count,
    output logic [streamPkg::slotWidth-1:0]     slot,
    input  logic                                grant
);
    import streamPkg::*;
    import computePkg::*;

    // Ports idle and count hide the state literals, so those two are scoped
    unitStateT            state;
    logic [dataWidth-1:0] botReg;
    opcodeT               opReg;
    logic [dataWidth-1:0] work;
    logic [dataWidth-1:0] combined;
    logic [dataWidth-1:0] firstClear;
    logic [dataWidth-1:0] secondClear;
    logic [1:0]           clearedBits;

    // top is sampled in load, after dispatch
    always_comb begin
        case (opReg)
            opAnd:   combined = top & botReg;
            opOr:    combined = top | botReg;
            opXor:   combined = top ^ botReg;
            default: combined = '0;
        endcase
    end

    // Drop the two lowest set bits
    assign firstClear = work & (work - 1'b1);
    assign secondClear = firstClear & (firstClear - 1'b1);
    assign clearedBits = {1'b0, work != '0} + {1'b0, firstClear != '0};

    assign idle = (state == computePkg::idle);
    assign done = (state == hold);

    always_ff @(posedge clk) begin
        if (start && state == computePkg::idle) begin
            botReg <= bot;
            opReg <= op;
            slot <= slotIn;
        end
        if (state == load) begin
            work <= combined;
            count <= '0;
        end else if (state == computePkg::count) begin
            work <= secondClear;
            count <= count + clearedBits;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= computePkg::idle;
        end else begin
            case (state)
                computePkg::idle: if (start) state <= load;
                load: state <= (combined == '0) ? hold : computePkg::count;
                computePkg::count: if (secondClear == '0) state <= hold;
                // Stall here until the arbiter takes the result
                hold: if (grant) state <= computePkg::idle;
                default: state <= computePkg::idle;
            endcase
        end
    end

endmodule

// ==== inputFifo.sv ====
module inputFifo (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                push,
    input  logic [streamPkg::dataWidth-1:0]     dataIn,
    input  computePkg::opcodeT                  opIn,
    input  logic [streamPkg::slotWidth-1:0]     slotIn,
    input  logic                                pop,
    output logic [streamPkg::dataWidth-1:0]     dataOut,
    output computePkg::opcodeT                  opOut,
    output logic [streamPkg::slotWidth-1:0]     slotOut,
    output logic                                headValid,
    output logic                                empty,
    output logic [streamPkg::fifoDepthLog2:0]   fillLevel
);
    import streamPkg::*;
    import computePkg::*;

    logic [dataWidth-1:0] dataMem [fifoDepth];
    opcodeT               opMem [fifoDepth];
    logic [slotWidth-1:0] slotMem [fifoDepth];
    logic [fifoDepthLog2:0] wrPtr;
    logic [fifoDepthLog2:0] rdPtr;
    logic full;
    logic doPush;
    logic doPop;

    // Extra pointer bit tells full from empty
    assign fillLevel = wrPtr - rdPtr;
    assign empty = (wrPtr == rdPtr);
    assign full = fillLevel[fifoDepthLog2];
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk) begin
        if (doPush) begin
            dataMem[wrPtr[fifoDepthLog2-1:0]] <= dataIn;
            opMem[wrPtr[fifoDepthLog2-1:0]] <= opIn;
            slotMem[wrPtr[fifoDepthLog2-1:0]] <= slotIn;
        end
        // Head stays put until the next pop
        if (doPop) begin
            dataOut <= dataMem[rdPtr[fifoDepthLog2-1:0]];
            opOut <= opMem[rdPtr[fifoDepthLog2-1:0]];
            slotOut <= slotMem[rdPtr[fifoDepthLog2-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            headValid <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            headValid <= doPop;
        end
    end

endmodule

// ==== resultCollector.sv ====
module resultCollector (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [streamPkg::slotWidth-1:0]     slotIndex,
    input  logic                                writeEnable,
    input  logic [streamPkg::countWidth-1:0]    writeCount,
    input  logic [streamPkg::slotWidth-1:0]     writeSlot,
    input  logic                                validIn,
    input  logic                                extraIn,
    output logic                                resultValid,
    output logic [streamPkg::countWidth-1:0]    count,
    output logic                                extraOut
);
    import streamPkg::*;

    logic [countWidth-1:0] countMem [slotCount];
    // Side data per slot, valid in bit 1
    logic [1:0]            sideMem [slotCount];
    logic [slotWidth-1:0]  readSlot;

    // One slot ahead so the registered output lines up with slotIndex
    assign readSlot = slotIndex + 1'b1;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            countMem[writeSlot] <= writeCount;
        end
        count <= countMem[readSlot];
    end

    // Cleared so the first ring pass shows nothing valid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < slotCount; i++) begin
                sideMem[i] <= 2'b00;
            end
            resultValid <= 1'b0;
            extraOut <= 1'b0;
        end else begin
            sideMem[slotIndex] <= {validIn, extraIn};
            resultValid <= sideMem[readSlot][1];
            extraOut <= sideMem[readSlot][0];
        end
    end

endmodule

// ==== sources.f ====
streamPkg.sv
computePkg.sv
inputFifo.sv
connectCounter.sv
collectorArbiter.sv
resultCollector.sv
streamingCountCore.sv
streamingCountCore_properties.sv
tbStreamingCountCore.sv

// ==== streamPkg.sv ====
package streamPkg;

    // Datapath widths
    localparam int dataWidth = 32;
    localparam int countWidth = 6;

    // Slot ring, one slot per input cycle
    localparam int slotWidth = 7;
    localparam int slotCount = 1 << slotWidth;

    // Input FIFO sizing
    localparam int fifoDepthLog2 = 4;
    localparam int fifoDepth = 1 << fifoDepthLog2;

    // Fill level above which the source is throttled
    localparam int slowThreshold = 2;

endpackage

// ==== streamingCountCore.sv ====
module streamingCountCore (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [streamPkg::dataWidth-1:0]     top,
    input  logic                                valid,
    input  logic [streamPkg::dataWidth-1:0]     bot,
    input  computePkg::opcodeT                  op,
    input  logic                                extraIn,
    output logic                                slowDown,
    output logic                                resultValid,
    output logic [streamPkg::countWidth-1:0]    count,
    output logic                                extraOut
);
    import streamPkg::*;
    import computePkg::*;

    logic [slotWidth-1:0]   slotIndex;
    logic [fifoDepthLog2:0] fillLevel;
    logic                   pop;
    logic                   headValid;
    logic                   fifoEmpty;
    logic [dataWidth-1:0]   headData;
    opcodeT                 headOp;
    logic [slotWidth-1:0]   headSlot;
    logic                   idle0;
    logic                   idle1;
    logic                   pending0;
    logic                   pending1;
    logic                   avail0;
    logic                   avail1;
    logic                   done0;
    logic                   done1;
    logic                   grant0;
    logic                   grant1;
    logic [countWidth-1:0]  count0;
    logic [countWidth-1:0]  count1;
    logic [slotWidth-1:0]   slot0;
    logic [slotWidth-1:0]   slot1;
    logic                   writeEnable;
    logic [countWidth-1:0]  writeCount;
    logic [slotWidth-1:0]   writeSlot;

    // A unit is free if idle and no popped word is already on its way
    assign avail0 = idle0 && !pending0;
    assign avail1 = idle1 && !pending1;
    assign pop = !fifoEmpty && (avail0 || avail1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slotIndex <= '0;
            pending0 <= 1'b0;
            pending1 <= 1'b0;
            slowDown <= 1'b0;
        end else begin
            slotIndex <= slotIndex + 1'b1;
            // Unit 0 wins when both are free
            pending0 <= pop && avail0;
            pending1 <= pop && !avail0 && avail1;
            slowDown <= (fillLevel > slowThreshold);
        end
    end

    inputFifo inputFifo_i (
        .clk(clk), .rstN(rstN),
        .push(valid), .dataIn(bot), .opIn(op), .slotIn(slotIndex),
        .pop(pop), .dataOut(headData), .opOut(headOp), .slotOut(headSlot),
        .headValid(headValid), .empty(fifoEmpty), .fillLevel(fillLevel)
    );

    connectCounter unit0_i (
        .clk(clk), .rstN(rstN), .start(headValid && pending0),
        .top(top), .bot(headData), .op(headOp), .slotIn(headSlot),
        .idle(idle0), .done(done0), .count(count0), .slot(slot0), .grant(grant0)
    );

    connectCounter unit1_i (
        .clk(clk), .rstN(rstN), .start(headValid && pending1),
        .top(top), .bot(headData), .op(headOp), .slotIn(headSlot),
        .idle(idle1), .done(done1), .count(count1), .slot(slot1), .grant(grant1)
    );

    collectorArbiter collectorArbiter_i (
        .clk(clk), .rstN(rstN), .done0(done0), .done1(done1),
        .count0(count0), .count1(count1), .slot0(slot0), .slot1(slot1),
        .grant0(grant0), .grant1(grant1), .writeEnable(writeEnable),
        .writeCount(writeCount), .writeSlot(writeSlot)
    );

    resultCollector resultCollector_i (
        .clk(clk), .rstN(rstN), .slotIndex(slotIndex),
        .writeEnable(writeEnable), .writeCount(writeCount), .writeSlot(writeSlot),
        .validIn(valid), .extraIn(extraIn),
        .resultValid(resultValid), .count(count), .extraOut(extraOut)
    );

endmodule

// ==== streamingCountCore_properties.sv ====
module streamingCountCoreProperties (
    input logic clk,
    input logic rstN,
    input logic done0,
    input logic done1,
    input logic grant0,
    input logic grant1,
    input logic slowDown
);

    int assertFails = 0;

    // Single write port on the result memory
    grantsExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(grant0 && grant1))
    else begin
        $error("both counting units granted in the same cycle");
        assertFails++;
    end

    // Round robin serves a waiting unit quickly
    doneGranted0: assert property (@(posedge clk) disable iff (!rstN)
        done0 |-> ##[0:2] grant0)
    else begin
        $error("unit 0 result not taken within 2 cycles");
        assertFails++;
    end

    doneGranted1: assert property (@(posedge clk) disable iff (!rstN)
        done1 |-> ##[0:2] grant1)
    else begin
        $error("unit 1 result not taken within 2 cycles");
        assertFails++;
    end

    slowDownAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !slowDown)
    else begin
        $error("slowDown high right after reset");
        assertFails++;
    end

endmodule

bind streamingCountCore streamingCountCoreProperties streamingCountCoreProperties_i (
    .clk(clk), .rstN(rstN), .done0(done0), .done1(done1),
    .grant0(grant0), .grant1(grant1), .slowDown(slowDown)
);

// ==== tbStreamingCountCore.sv ====
module tbStreamingCountCore;
    import streamPkg::*;
    import computePkg::*;

    localparam int clkPeriod = 20;
    localparam int tableRows = 40;
    localparam int randomRows = 60;
    localparam int settleCycles = 80;
    localparam int flushCycles = slotCount + 10;
    // A word never needs more than 20 cycles in a unit, stalls included
    localparam int watchdogTime =
        ((tableRows + randomRows) * 20 + 2 * settleCycles + flushCycles + 300) * clkPeriod;

    localparam logic [31:0] topPatterns [3] = '{32'hFFFFFFFF, 32'h00000000, 32'hA5A5A5A5};

    // Row nibbles: valid, extra, op, top phase, then bot
    localparam logic [47:0] stimTable [tableRows] = '{
        48'h1_0_0_0_FFFFFFFF, 48'h1_1_0_0_00000000, 48'h1_0_0_0_00010001, 48'h0_0_0_0_00000000,
        48'h1_1_1_0_00000000, 48'h1_0_2_0_FFFFFFFF, 48'h1_1_2_0_00000000, 48'h1_0_3_0_FFFFFFFF,
        48'h0_0_0_0_00000000,
        // Dense burst, both units busy and the FIFO backs up
        48'h1_0_1_0_12345678, 48'h1_1_1_0_00000000, 48'h1_0_1_0_FFFFFFFF, 48'h1_1_1_0_0F0F0F0F,
        48'h1_0_1_0_80000000, 48'h1_1_1_0_00000001, 48'h1_0_1_0_55555555, 48'h1_1_1_0_AAAAAAAA,
        48'h1_0_0_0_80000001, 48'h0_0_0_0_00000000, 48'h1_1_2_0_0000FFFF,
        48'h1_0_0_1_FFFFFFFF, 48'h1_1_1_1_FFFFFFFF, 48'h1_0_1_1_80000001, 48'h1_1_2_1_12345678,
        48'h0_0_0_1_00000000, 48'h1_0_3_1_FFFFFFFF, 48'h1_1_1_1_00000000, 48'h1_0_2_1_F0F0F0F0,
        48'h1_1_0_2_FFFFFFFF, 48'h1_0_1_2_5A5A5A5A, 48'h1_1_2_2_A5A5A5A5, 48'h1_0_2_2_00000000,
        48'h1_1_0_2_0F0F0F0F, 48'h0_0_0_2_00000000, 48'h1_0_1_2_FFFFFFFF, 48'h1_1_1_2_FFFF0000,
        48'h1_0_1_2_0000FFFF, 48'h1_1_3_2_A5A5A5A5, 48'h0_0_0_2_00000000, 48'h1_1_0_2_00000001
    };

    logic clk;
    logic rstN;
    logic [dataWidth-1:0] top;
    logic valid;
    logic [dataWidth-1:0] bot;
    opcodeT op;
    logic extraIn;
    logic slowDown;
    logic resultValid;
    logic [countWidth-1:0] count;
    logic extraOut;

    // Per applied cycle: {valid, extra, count}
    logic [7:0] expected [$];
    int errorCount = 0;
    int checkCount = 0;
    bit sawSlowDown = 1'b0;

    streamingCountCore streamingCountCore_i (
        .clk(clk), .rstN(rstN), .top(top), .valid(valid), .bot(bot), .op(op),
        .extraIn(extraIn), .slowDown(slowDown), .resultValid(resultValid),
        .count(count), .extraOut(extraOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [countWidth-1:0] expectedCount(
        input logic [31:0] t, input logic [31:0] b, input opcodeT o);
        logic [31:0] mixed;
        logic [countWidth-1:0] n;
        case (o)
            opAnd: mixed = t & b;
            opOr: mixed = t | b;
            opXor: mixed = t ^ b;
            default: mixed = '0;
        endcase
        n = '0;
        for (int i = 0; i < 32; i++) begin
            n = n + mixed[i];
        end
        return n;
    endfunction

    // Output now belongs to the input applied slotCount cycles ago
    task automatic checkOutputs();
        int k;
        logic [7:0] entry;
        k = expected.size();
        entry = (k < slotCount) ? 8'h00 : expected[k - slotCount];
        checkCount++;
        if (resultValid !== entry[7]) begin
            $display("** Error at %0t: resultValid expected %0b, got %0b",
                     $time, entry[7], resultValid);
            errorCount++;
        end else if (entry[7]) begin
            if (count !== entry[5:0]) begin
                $display("** Error at %0t: count expected %0d, got %0d",
                         $time, entry[5:0], count);
                errorCount++;
            end
            if (extraOut !== entry[6]) begin
                $display("** Error at %0t: extraOut expected %0b, got %0b",
                         $time, entry[6], extraOut);
                errorCount++;
            end
        end
    endtask

    task automatic applyCycle(input logic v, input logic [31:0] b, input opcodeT o,
                              input logic e);
        checkOutputs();
        valid = v;
        bot = b;
        op = o;
        extraIn = e;
        expected.push_back({v, v & e, v ? expectedCount(top, b, o) : 6'd0});
        @(negedge clk);
    endtask

    // Source honors the slow-down level
    task automatic waitForRoom();
        while (slowDown) begin
            sawSlowDown = 1'b1;
            applyCycle(1'b0, '0, opNone, 1'b0);
        end
    endtask

    initial begin
        logic [47:0] row;
        logic [1:0] phase;
        integer seed;
        logic [31:0] r;
        logic [31:0] rb;
        int assertFails;
        rstN = 1'b0;
        valid = 1'b0;
        bot = '0;
        op = opAnd;
        extraIn = 1'b0;
        top = topPatterns[0];
        seed = 23547;
        phase = 2'd0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < tableRows; i++) begin
            row = stimTable[i];
            // Let words already in flight load the old top first
            if (row[33:32] != phase) begin
                repeat (settleCycles) applyCycle(1'b0, '0, opNone, 1'b0);
                phase = row[33:32];
                top = topPatterns[phase];
            end
            if (row[44]) begin
                waitForRoom();
            end
            applyCycle(row[44], row[31:0], opcodeT'(row[37:36]), row[40]);
        end
        for (int i = 0; i < randomRows; i++) begin
            r = $random(seed);
            rb = $random(seed);
            if (r[0]) begin
                waitForRoom();
            end
            applyCycle(r[0], rb, opcodeT'(r[3:2]), r[4]);
        end
        repeat (flushCycles) applyCycle(1'b0, '0, opNone, 1'b0);
        // FIFO has drained by now
        if (!sawSlowDown) begin
            $display("slowDown never rose while the FIFO was backed up");
            errorCount++;
        end
        if (slowDown !== 1'b0) begin
            $display("** Error at %0t: slowDown expected 0, got %0b", $time, slowDown);
            errorCount++;
        end
        assertFails = streamingCountCore_i.streamingCountCoreProperties_i.assertFails;
        $display("Done: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("Timeout: stimulus did not finish within the time limit");
        $display("sim failed");
        $finish;
    end

endmodule
